/* source/zxuno_pkg.sv */
package zxuno_pkg;

  // --------------------------------------------------
  // I/O port map
  // --------------------------------------------------

  // ZX-Uno register address port
  localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
  // ZX-Uno register data port
  localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

  // Register numbers behind the data port
  localparam logic [7:0] REG_DEVOPTIONS = 8'h0E;
  localparam logic [7:0] REG_SCRATCH    = 8'hFE;
  localparam logic [7:0] REG_COREID     = 8'hFF;

  // Core id string, zero terminated, first character in the top byte
  localparam int CORE_ID_LEN    = 8;
  localparam int CORE_ID_PTR_W  = $clog2(CORE_ID_LEN);
  localparam logic [8*CORE_ID_LEN-1:0] CORE_ID = {"ZXIO-01", 8'h00};

  // Pulled-up data bus, also the value forced on interrupt acknowledge
  localparam logic [7:0] BUS_IDLE_VALUE = 8'hFF;

  // --------------------------------------------------
  // Bus and register types
  // --------------------------------------------------

  // CPU side of the bus, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } cpu_bus_t;

  // One read-data source
  typedef struct packed {
    logic       oe;
    logic [7:0] data;
  } read_src_t;

  // Device enable flags, MSB first
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } devoptions_t;

  // Same byte seen by the CPU as raw and by the rest of the core as flags
  typedef union packed {
    logic [7:0]  raw;
    devoptions_t flags;
  } devoptions_u;

  // ULA output bits
  typedef struct packed {
    logic [2:0] border;
    logic       mic;
    logic       spk;
  } ula_out_t;

endpackage

/* source/coreid_string.sv */
`timescale 1ns/1ps

module coreid_string
  import zxuno_pkg::*;
(
  input  logic       sysclk,
  input  logic       reset,
  input  logic       rewind,
  input  logic       next,
  output logic [7:0] char
);

  // Index of the character shown on the next read
  logic [CORE_ID_PTR_W-1:0] ptr;
  // Pointer sits on the terminator
  logic                     at_last;

  assign at_last = (ptr == CORE_ID_PTR_W'(CORE_ID_LEN - 1));

  // --------------------------------------------------
  // Character pointer
  // --------------------------------------------------

  always_ff @(posedge sysclk) begin
    if (reset) begin
      ptr <= '0;
    end else if (rewind) begin
      // Address port write restarts the string
      ptr <= '0;
    end else if (next) begin
      if (at_last) begin
        // Wrap after the zero byte
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // First character lives in the top byte of CORE_ID
  assign char = CORE_ID[8*(CORE_ID_LEN-1-int'(ptr)) +: 8];

endmodule

/* source/zxuno_regbank.sv */
`timescale 1ns/1ps

module zxuno_regbank
  import zxuno_pkg::*;
(
  input  logic        sysclk,
  input  logic        reset,
  input  cpu_bus_t    bus,
  output read_src_t   rd,
  output devoptions_t devoptions
);

  // Decode
  logic        io_cycle;
  logic        sel_addr_port;
  logic        sel_data_port;
  // Strobes
  logic        iorq_q;
  logic        first_clk;
  logic        addr_wr;
  logic        data_wr;
  logic        data_rd;
  logic        data_rd_q;
  logic        read_done;
  logic        regaddr_changed;
  // Registers
  logic [7:0]  zxuno_addr;
  logic [7:0]  scratch;
  devoptions_u devopts;
  // Core id sequencer hookup
  logic        coreid_next;
  logic [7:0]  coreid_char;

  // --------------------------------------------------
  // Port decode on the full 16-bit address
  // --------------------------------------------------

  // Interrupt acknowledge is not an I/O access here
  assign io_cycle      = !bus.iorq_n && bus.m1_n;
  assign sel_addr_port = io_cycle && (bus.addr == ZXUNO_ADDR_PORT);
  assign sel_data_port = io_cycle && (bus.addr == ZXUNO_DATA_PORT);

  // First clock with iorq_n low
  assign first_clk = iorq_q && !bus.iorq_n;

  // One write per bus cycle, in its first clock
  assign addr_wr = sel_addr_port && first_clk && !bus.wr_n;
  assign data_wr = sel_data_port && first_clk && !bus.wr_n;

  // Data port read in progress
  assign data_rd = sel_data_port && !bus.rd_n;

  // Clock after iorq_n rises, only if that cycle was a data port read
  assign read_done = bus.iorq_n && !iorq_q && data_rd_q;

  // Address port written, lasts the strobe clock only
  assign regaddr_changed = addr_wr;

  // Step the id string only when it is the selected register
  assign coreid_next = read_done && (zxuno_addr == REG_COREID);

  always_ff @(posedge sysclk) begin
    if (reset) begin
      iorq_q    <= 1'b1;
      data_rd_q <= 1'b0;
    end else begin
      iorq_q    <= bus.iorq_n;
      data_rd_q <= data_rd;
    end
  end

  // --------------------------------------------------
  // Address, scratch and device options
  // --------------------------------------------------

  always_ff @(posedge sysclk) begin
    if (reset) begin
      zxuno_addr  <= '0;
      scratch     <= '0;
      devopts.raw <= '0;
    end else begin
      if (addr_wr) begin
        zxuno_addr <= bus.dout;
      end
      // Data port writes land in the selected register
      if (data_wr && (zxuno_addr == REG_SCRATCH)) begin
        scratch <= bus.dout;
      end
      if (data_wr && (zxuno_addr == REG_DEVOPTIONS)) begin
        devopts.raw <= bus.dout;
      end
    end
  end

  // Flags view goes out to the rest of the core
  assign devoptions = devopts.flags;

  // Id string, rewound by any address port write
  coreid_string u_coreid (
    .sysclk (sysclk),
    .reset  (reset),
    .rewind (regaddr_changed),
    .next   (coreid_next),
    .char   (coreid_char)
  );

  // --------------------------------------------------
  // Read-back
  // --------------------------------------------------

  always_comb begin
    rd.oe   = 1'b0;
    rd.data = BUS_IDLE_VALUE;
    if (sel_addr_port && !bus.rd_n) begin
      rd.oe   = 1'b1;
      rd.data = zxuno_addr;
    end else if (data_rd) begin
      // Unimplemented registers leave the bus alone
      case (zxuno_addr)
        REG_SCRATCH: begin
          rd.oe   = 1'b1;
          rd.data = scratch;
        end
        REG_DEVOPTIONS: begin
          rd.oe   = 1'b1;
          rd.data = devopts.raw;
        end
        REG_COREID: begin
          rd.oe   = 1'b1;
          rd.data = coreid_char;
        end
        default: begin
          rd.oe   = 1'b0;
          rd.data = BUS_IDLE_VALUE;
        end
      endcase
    end
  end

endmodule

/* source/ula_port.sv */
`timescale 1ns/1ps

module ula_port
  import zxuno_pkg::*;
(
  input  logic       sysclk,
  input  logic       reset,
  input  cpu_bus_t   bus,
  input  logic       ear,
  input  logic [4:0] kbdcol,
  output read_src_t  rd,
  output ula_out_t   ula_out
);

  // Any even port address
  logic sel;
  // Registered iorq_n for the first-clock strobe
  logic iorq_q;
  logic ula_wr;

  assign sel    = !bus.iorq_n && !bus.addr[0];
  assign ula_wr = sel && iorq_q && !bus.wr_n;

  always_ff @(posedge sysclk) begin
    if (reset) begin
      iorq_q <= 1'b1;
    end else begin
      iorq_q <= bus.iorq_n;
    end
  end

  // --------------------------------------------------
  // Border, mic and speaker
  // --------------------------------------------------

  always_ff @(posedge sysclk) begin
    if (reset) begin
      ula_out <= '0;
    end else if (ula_wr) begin
      ula_out.border <= bus.dout[2:0];
      ula_out.mic    <= bus.dout[3];
      ula_out.spk    <= bus.dout[4];
    end
  end

  // Keyboard columns with ear, unused bits read as one
  assign rd.oe   = sel && !bus.rd_n;
  assign rd.data = {1'b1, ear, 1'b1, kbdcol};

endmodule

/* source/cpu_data_mux.sv */
`timescale 1ns/1ps

module cpu_data_mux
  import zxuno_pkg::*;
(
  input  cpu_bus_t   bus,
  input  read_src_t  zxuno_rd,
  input  read_src_t  ula_rd,
  output logic [7:0] cpudin
);

  // IM acknowledge cycle
  logic oe_intack;

  assign oe_intack = !bus.iorq_n && !bus.m1_n;

  // --------------------------------------------------
  // Priority select
  // --------------------------------------------------

  always_comb begin
    if (oe_intack) begin
      // Forced value during an accepted interrupt
      cpudin = BUS_IDLE_VALUE;
    end else if (zxuno_rd.oe) begin
      cpudin = zxuno_rd.data;
    end else if (ula_rd.oe) begin
      cpudin = ula_rd.data;
    end else begin
      // Nobody drives, pull-ups win
      cpudin = BUS_IDLE_VALUE;
    end
  end

endmodule

/* source/zxuno_io.sv */
`timescale 1ns/1ps

module zxuno_io
  import zxuno_pkg::*;
(
  input  logic        sysclk,
  input  logic        reset,
  input  cpu_bus_t    bus,
  input  logic        ear,
  input  logic [4:0]  kbdcol,
  output logic [7:0]  cpudin,
  output devoptions_t devoptions,
  output ula_out_t    ula_out
);

  // Read sources toward the CPU
  read_src_t zxuno_rd;
  read_src_t ula_rd;

  // --------------------------------------------------
  // Bus slaves, side by side
  // --------------------------------------------------

  // ZX-Uno address and data ports
  zxuno_regbank u_regbank (
    .sysclk     (sysclk),
    .reset      (reset),
    .bus        (bus),
    .rd         (zxuno_rd),
    .devoptions (devoptions)
  );

  // Even port ULA register
  ula_port u_ula_port (
    .sysclk  (sysclk),
    .reset   (reset),
    .bus     (bus),
    .ear     (ear),
    .kbdcol  (kbdcol),
    .rd      (ula_rd),
    .ula_out (ula_out)
  );

  // CPU data in
  cpu_data_mux u_data_mux (
    .bus      (bus),
    .zxuno_rd (zxuno_rd),
    .ula_rd   (ula_rd),
    .cpudin   (cpudin)
  );

endmodule

/* verif/zxuno_ref.svh */
`ifndef ZXUNO_REF_SVH
`define ZXUNO_REF_SVH

// --------------------------------------------------
// Reference model state
// --------------------------------------------------

// Core id text, a zero byte follows the last character
string      id_text = "ZXIO-01";

logic [7:0] m_addr;
logic [7:0] m_scratch;
logic [7:0] m_devopts;
// Index of the next id character, terminator at id_text.len()
int         m_ptr;
logic [2:0] m_border;
logic       m_mic;
logic       m_spk;
logic       m_ear;
logic [4:0] m_kbdcol;

function automatic void ref_reset();
  m_addr    = 8'h00;
  m_scratch = 8'h00;
  m_devopts = 8'h00;
  m_ptr     = 0;
  m_border  = 3'b000;
  m_mic     = 1'b0;
  m_spk     = 1'b0;
  m_ear     = 1'b0;
  m_kbdcol  = 5'b00000;
endfunction

function automatic logic [7:0] ref_id_char(input int idx);
  if (idx < id_text.len()) begin
    return id_text[idx];
  end
  // Terminator
  return 8'h00;
endfunction

// ULA outputs packed as border, mic, spk
function automatic logic [7:0] ref_ula();
  return {3'b000, m_border, m_mic, m_spk};
endfunction

// --------------------------------------------------
// Expected read value for one port address
// --------------------------------------------------

function automatic logic [7:0] ref_read(input logic [15:0] addr);
  if (addr == ZXUNO_ADDR_PORT) begin
    return m_addr;
  end
  if (addr == ZXUNO_DATA_PORT) begin
    if (m_addr == REG_SCRATCH) begin
      return m_scratch;
    end
    if (m_addr == REG_DEVOPTIONS) begin
      return m_devopts;
    end
    if (m_addr == REG_COREID) begin
      return ref_id_char(m_ptr);
    end
    // Nothing answers, bus floats high
    return 8'hFF;
  end
  if (!addr[0]) begin
    return {1'b1, m_ear, 1'b1, m_kbdcol};
  end
  return 8'hFF;
endfunction

function automatic void ref_write(input logic [15:0] addr, input logic [7:0] data);
  if (addr == ZXUNO_ADDR_PORT) begin
    m_addr = data;
    // Restart of the id string
    m_ptr  = 0;
  end else if (addr == ZXUNO_DATA_PORT) begin
    if (m_addr == REG_SCRATCH) begin
      m_scratch = data;
    end
    if (m_addr == REG_DEVOPTIONS) begin
      m_devopts = data;
    end
  end else if (!addr[0]) begin
    m_border = data[2:0];
    m_mic    = data[3];
    m_spk    = data[4];
  end
endfunction

// Completed read, steps the id string when it is selected
function automatic void ref_read_done(input logic [15:0] addr);
  if (addr == ZXUNO_DATA_PORT && m_addr == REG_COREID) begin
    if (m_ptr == id_text.len()) begin
      m_ptr = 0;
    end else begin
      m_ptr = m_ptr + 1;
    end
  end
endfunction

`endif

/* verif/tb_zxuno_io.sv */
`timescale 1ns/1ps

module tb_zxuno_io
  import zxuno_pkg::*;
();

  localparam int MAX_CYCLES = 5000;
  localparam int N_ITER     = 32;

  logic        sysclk;
  logic        reset;
  cpu_bus_t    bus;
  logic        ear;
  logic [4:0]  kbdcol;
  logic [7:0]  cpudin;
  devoptions_t devoptions;
  ula_out_t    ula_out;

  // Values captured in the second clock of a bus cycle
  logic [7:0]  snap_cpudin;
  logic [7:0]  snap_devopt;
  logic [4:0]  snap_ula;

  // Pending comparisons
  string       name_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  act_q[$];
  string       cmp_name;
  logic [7:0]  cmp_exp;
  logic [7:0]  cmp_act;

  string       cur_test;
  int          n_pass = 0;
  int          n_fail = 0;
  int          base_pass;
  int          base_fail;
  int          cycles = 0;

  `include "zxuno_ref.svh"

  zxuno_io DUT (
    .sysclk     (sysclk),
    .reset      (reset),
    .bus        (bus),
    .ear        (ear),
    .kbdcol     (kbdcol),
    .cpudin     (cpudin),
    .devoptions (devoptions),
    .ula_out    (ula_out)
  );

  // 20 ns clock
  initial begin
    sysclk = 1'b0;
    forever begin
      #10 sysclk = ~sysclk;
    end
  end

  // Run limit
  always @(posedge sysclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d clock cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------

  always @(posedge sysclk) begin
    while (exp_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      if (cmp_act !== cmp_exp) begin
        $display("error %s: expected 0x%02h, actual 0x%02h", cmp_name, cmp_exp, cmp_act);
        n_fail = n_fail + 1;
      end else begin
        n_pass = n_pass + 1;
      end
    end
  end

  function automatic void queue_check(input string name, input logic [7:0] exp,
                                      input logic [7:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endfunction

  // --------------------------------------------------
  // Bus cycles
  // --------------------------------------------------

  // Strobes low for 3 clocks, snapshot in the second
  task automatic run_cycle(input logic [15:0] addr, input logic [7:0] data,
                           input logic rd_n, input logic wr_n, input logic m1_n);
    cpu_bus_t b;
    b.addr   = addr;
    b.dout   = data;
    b.iorq_n = 1'b0;
    b.rd_n   = rd_n;
    b.wr_n   = wr_n;
    b.m1_n   = m1_n;
    @(posedge sysclk);
    bus <= b;
    @(posedge sysclk);
    @(negedge sysclk);
    snap_cpudin = cpudin;
    snap_devopt = devoptions;
    snap_ula    = ula_out;
    @(posedge sysclk);
    @(posedge sysclk);
    b.iorq_n = 1'b1;
    b.rd_n   = 1'b1;
    b.wr_n   = 1'b1;
    b.m1_n   = 1'b1;
    bus <= b;
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    run_cycle(addr, data, 1'b1, 1'b0, 1'b1);
    ref_write(addr, data);
  endtask

  task automatic read_and_check(input logic [15:0] addr);
    run_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b1);
    queue_check(cur_test, ref_read(addr), snap_cpudin);
    ref_read_done(addr);
  endtask

  // Interrupt acknowledge with rd_n low, so a selected port would answer
  task automatic intack_and_check(input logic [15:0] addr);
    run_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b0);
    queue_check(cur_test, 8'hFF, snap_cpudin);
  endtask

  task automatic set_ear_kbd(input logic e, input logic [4:0] k);
    @(posedge sysclk);
    ear    <= e;
    kbdcol <= k;
    m_ear    = e;
    m_kbdcol = k;
  endtask

  function automatic logic [7:0] pick_unused_reg();
    logic [7:0] r;
    r = 8'($urandom);
    while (r == REG_SCRATCH || r == REG_DEVOPTIONS || r == REG_COREID) begin
      r = 8'($urandom);
    end
    return r;
  endfunction

  function automatic void begin_test(input string name);
    cur_test  = name;
    base_pass = n_pass;
    base_fail = n_fail;
  endfunction

  // Let the compare process drain first
  task automatic end_test();
    @(posedge sysclk);
    @(negedge sysclk);
    $display("test %-10s done, %0d checks, %0d errors", cur_test,
             (n_pass - base_pass) + (n_fail - base_fail), n_fail - base_fail);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  initial begin
    void'($urandom(73));
    reset  = 1'b1;
    bus    = '1;
    bus.addr = 16'h0000;
    bus.dout = 8'h00;
    ear    = 1'b0;
    kbdcol = 5'b00000;
    ref_reset();
    repeat (2) @(posedge sysclk);
    reset <= 1'b0;

    begin_test("reset");
    @(negedge sysclk);
    queue_check(cur_test, m_devopts, devoptions);
    queue_check(cur_test, ref_ula(), {3'b000, ula_out});
    read_and_check(ZXUNO_ADDR_PORT);
    end_test();

    begin_test("address");
    for (int i = 0; i < N_ITER; i++) begin
      bus_write(ZXUNO_ADDR_PORT, 8'($urandom));
      read_and_check(ZXUNO_ADDR_PORT);
    end
    end_test();

    begin_test("scratch");
    bus_write(ZXUNO_ADDR_PORT, REG_SCRATCH);
    for (int i = 0; i < N_ITER; i++) begin
      bus_write(ZXUNO_DATA_PORT, 8'($urandom));
      read_and_check(ZXUNO_DATA_PORT);
    end
    end_test();

    // Registers nobody implements read as 0xFF
    begin_test("unimpl");
    for (int i = 0; i < 4; i++) begin
      bus_write(ZXUNO_ADDR_PORT, pick_unused_reg());
      read_and_check(ZXUNO_DATA_PORT);
    end
    end_test();

    begin_test("devoptions");
    bus_write(ZXUNO_ADDR_PORT, REG_DEVOPTIONS);
    for (int i = 0; i < N_ITER; i++) begin
      bus_write(ZXUNO_DATA_PORT, 8'($urandom));
      // Flags one clock after the strobe
      queue_check(cur_test, m_devopts, snap_devopt);
      read_and_check(ZXUNO_DATA_PORT);
    end
    end_test();

    // Two full passes plus a few, then restart mid string
    begin_test("coreid");
    bus_write(ZXUNO_ADDR_PORT, REG_COREID);
    for (int i = 0; i < 19; i++) begin
      read_and_check(ZXUNO_DATA_PORT);
    end
    bus_write(ZXUNO_ADDR_PORT, REG_COREID);
    for (int i = 0; i < 3; i++) begin
      read_and_check(ZXUNO_DATA_PORT);
    end
    end_test();

    begin_test("ula");
    for (int i = 0; i < N_ITER; i++) begin
      bus_write(16'($urandom) & 16'hFFFE, 8'($urandom));
      queue_check(cur_test, ref_ula(), {3'b000, snap_ula});
      set_ear_kbd(1'($urandom), 5'($urandom));
      read_and_check(16'($urandom) & 16'hFFFE);
    end
    end_test();

    begin_test("intack");
    // ULA port would answer 0xA0 here
    set_ear_kbd(1'b0, 5'b00000);
    intack_and_check(16'($urandom) & 16'hFFFE);
    intack_and_check(ZXUNO_ADDR_PORT);
    intack_and_check(ZXUNO_DATA_PORT);
    // Normal read afterwards, id pointer untouched
    read_and_check(ZXUNO_DATA_PORT);
    end_test();

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+verif
source/zxuno_pkg.sv
source/coreid_string.sv
source/zxuno_regbank.sv
source/ula_port.sv
source/cpu_data_mux.sv
source/zxuno_io.sv
verif/tb_zxuno_io.sv

/* run.sh */
#!/bin/sh
# Build and run the zxuno_io testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_zxuno_io -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_zxuno_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
